/* uart_loader_pkg.sv */
package uart_loader_pkg;

    // serial timing, kept short for simulation
    localparam int CLKS_PER_BIT = 8;

    localparam int BYTE_W = 8;
    localparam int BLOCK_W = 128;
    localparam int BYTES_PER_BLOCK = 16;

    // block memory
    localparam int MAX_BLOCKS = 256;
    localparam int ADDR_W = 8;

    // byte position within a key or block
    localparam int COUNT_W = 5;

    typedef enum logic [2:0] {
        WAIT_COUNT,
        GET_KEY,
        KEY_DONE,
        GET_BLOCK,
        BLOCK_DONE,
        HANDOFF
    } loader_state_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_WAIT,
        LOAD,
        SEND,
        NEXT,
        FINISH
    } unload_state_t;

endpackage

/* uart_rx.sv */
`timescale 1ns/1ns

module uart_rx import uart_loader_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_rx,
    output logic              o_valid,
    output logic [BYTE_W-1:0] o_byte
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t                       state;
    logic                            rx_meta;
    logic                            rx_sync;
    logic                            rx_prev;
    logic [$clog2(CLKS_PER_BIT)-1:0] phase;
    logic [$clog2(BYTE_W)-1:0]       bit_idx;
    logic [BYTE_W-1:0]               shift;
    logic                            bit_end;

    assign bit_end = (phase == CLKS_PER_BIT - 1);

    // two-flop synchronizer plus one stage for edge detect
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= RX_IDLE;
            phase   <= '0;
            bit_idx <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    phase   <= '0;
                    bit_idx <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // middle of start bit, false start if line went back high
                    if (phase == CLKS_PER_BIT / 2 - 1) begin
                        phase <= '0;
                        state <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        phase <= '0;
                        if (bit_idx == BYTE_W - 1) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        phase   <= '0;
                        state   <= RX_IDLE;
                        o_valid <= rx_sync;
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data lsb first
    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && bit_end) begin
            shift <= {rx_sync, shift[BYTE_W-1:1]};
        end
        if (state == RX_STOP && bit_end) begin
            o_byte <= shift;
        end
    end

endmodule

/* uart_tx.sv */
`timescale 1ns/1ns

module uart_tx import uart_loader_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    input  logic [BYTE_W-1:0] i_byte,
    output logic              o_ready,
    output logic              o_tx
);

    logic                            busy;
    logic [BYTE_W+1:0]               tx_shift;
    logic [$clog2(CLKS_PER_BIT)-1:0] phase;
    logic [$clog2(BYTE_W+2)-1:0]     bit_cnt;

    assign o_ready = !busy;
    assign o_tx    = tx_shift[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            tx_shift <= '1;
            phase    <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            phase   <= '0;
            bit_cnt <= '0;
            if (i_valid) begin
                // stop, data, start
                busy     <= 1'b1;
                tx_shift <= {1'b1, i_byte, 1'b0};
            end
        end else if (phase == CLKS_PER_BIT - 1) begin
            phase    <= '0;
            tx_shift <= {1'b1, tx_shift[BYTE_W+1:1]};
            if (bit_cnt == BYTE_W + 1) begin
                // end of stop bit
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            phase <= phase + 1'b1;
        end
    end

endmodule

/* frame_loader.sv */
`timescale 1ns/1ns

module frame_loader import uart_loader_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_rx_valid,
    input  logic [BYTE_W-1:0]  i_rx_byte,
    input  logic               i_tx_ready,
    input  logic               i_unload_busy,
    output logic               o_echo_valid,
    output logic [BYTE_W-1:0]  o_echo_byte,
    output logic [BLOCK_W-1:0] o_key,
    output logic               o_key_valid,
    output logic               o_we,
    output logic [ADDR_W-1:0]  o_waddr,
    output logic [BLOCK_W-1:0] o_wdata,
    output logic               o_start,
    output logic [ADDR_W-1:0]  o_count
);

    loader_state_t       state;
    logic [COUNT_W-1:0]  byte_cnt;
    logic [BLOCK_W-1:0]  key_sr;
    logic [BLOCK_W-1:0]  blk_sr;
    logic                last_byte;

    assign last_byte   = (byte_cnt == BYTES_PER_BLOCK - 1);
    assign o_key       = key_sr;
    assign o_key_valid = (state == KEY_DONE);
    assign o_we        = (state == BLOCK_DONE);
    assign o_wdata     = blk_sr;
    assign o_start     = (state == HANDOFF);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= WAIT_COUNT;
            byte_cnt <= '0;
            o_waddr  <= '0;
            o_count  <= '0;
        end else begin
            case (state)
                WAIT_COUNT: begin
                    byte_cnt <= '0;
                    o_waddr  <= '0;
                    // hold off while the previous frame is still read back
                    if (i_rx_valid && !i_unload_busy) begin
                        o_count <= i_rx_byte;
                        state   <= GET_KEY;
                    end
                end
                GET_KEY: begin
                    if (i_rx_valid) begin
                        if (last_byte) begin
                            byte_cnt <= '0;
                            state    <= KEY_DONE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                KEY_DONE: begin
                    state <= (o_count == '0) ? HANDOFF : GET_BLOCK;
                end
                GET_BLOCK: begin
                    if (i_rx_valid) begin
                        if (last_byte) begin
                            byte_cnt <= '0;
                            state    <= BLOCK_DONE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                BLOCK_DONE: begin
                    o_waddr <= o_waddr + 1'b1;
                    state   <= (o_waddr == o_count - 1'b1) ? HANDOFF : GET_BLOCK;
                end
                HANDOFF: state <= WAIT_COUNT;
                default: state <= WAIT_COUNT;
            endcase
        end
    end

    // earliest byte ends up most significant
    always_ff @(posedge clk) begin
        if (i_rx_valid && state == GET_KEY) begin
            key_sr <= {key_sr[BLOCK_W-BYTE_W-1:0], i_rx_byte};
        end
        if (i_rx_valid && state == GET_BLOCK) begin
            blk_sr <= {blk_sr[BLOCK_W-BYTE_W-1:0], i_rx_byte};
        end
    end

    // every received byte goes back once
    always_ff @(posedge clk) begin
        if (rst) begin
            o_echo_valid <= 1'b0;
        end else if (i_rx_valid) begin
            o_echo_valid <= 1'b1;
        end else if (o_echo_valid && i_tx_ready) begin
            o_echo_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rx_valid) begin
            o_echo_byte <= i_rx_byte;
        end
    end

endmodule

/* block_ram.sv */
`timescale 1ns/1ns

module block_ram import uart_loader_pkg::*; (
    input  logic               clk,
    input  logic               i_we,
    input  logic [ADDR_W-1:0]  i_waddr,
    input  logic [BLOCK_W-1:0] i_wdata,
    input  logic [ADDR_W-1:0]  i_raddr,
    output logic [BLOCK_W-1:0] o_rdata
);

    logic [BLOCK_W-1:0] mem [MAX_BLOCKS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

/* block_unloader.sv */
`timescale 1ns/1ns

module block_unloader import uart_loader_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_start,
    input  logic [ADDR_W-1:0]  i_count,
    output logic [ADDR_W-1:0]  o_raddr,
    input  logic [BLOCK_W-1:0] i_rdata,
    input  logic               i_tx_ready,
    output logic               o_send_valid,
    output logic [BYTE_W-1:0]  o_send_byte,
    output logic               o_busy,
    output logic               o_done
);

    unload_state_t       state;
    logic [ADDR_W-1:0]   count_q;
    logic [COUNT_W-1:0]  byte_cnt;
    logic [BLOCK_W-1:0]  out_sr;
    logic                xfer;

    assign o_send_valid = (state == SEND);
    assign o_send_byte  = out_sr[BYTE_W-1:0];
    assign o_busy       = (state != IDLE);
    assign o_done       = (state == FINISH);
    assign xfer         = o_send_valid && i_tx_ready;

    // raddr rests at 0 so block 0 is already being read when start comes
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            o_raddr  <= '0;
            byte_cnt <= '0;
            count_q  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    byte_cnt <= '0;
                    if (i_start) begin
                        count_q <= i_count;
                        state   <= (i_count == '0) ? FINISH : LOAD;
                    end
                end
                READ_WAIT: state <= LOAD;
                LOAD: begin
                    byte_cnt <= '0;
                    state    <= SEND;
                end
                SEND: begin
                    if (xfer) begin
                        if (byte_cnt == BYTES_PER_BLOCK - 1) begin
                            byte_cnt <= '0;
                            state    <= (o_raddr == count_q - 1'b1) ? FINISH : NEXT;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                NEXT: begin
                    o_raddr <= o_raddr + 1'b1;
                    state   <= READ_WAIT;
                end
                FINISH: begin
                    o_raddr <= '0;
                    state   <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // low byte out first
    always_ff @(posedge clk) begin
        if (state == LOAD) begin
            out_sr <= i_rdata;
        end else if (xfer) begin
            out_sr <= {{BYTE_W{1'b0}}, out_sr[BLOCK_W-1:BYTE_W]};
        end
    end

endmodule

/* uart_loader_top.sv */
`timescale 1ns/1ns

module uart_loader_top import uart_loader_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_uart_rx,
    output logic               o_uart_tx,
    output logic [BLOCK_W-1:0] o_key,
    output logic               o_key_valid,
    output logic               o_readback_done
);

    logic               rx_valid;
    logic [BYTE_W-1:0]  rx_byte;
    logic               tx_valid;
    logic [BYTE_W-1:0]  tx_byte;
    logic               tx_ready;
    logic               echo_valid;
    logic [BYTE_W-1:0]  echo_byte;
    logic               we;
    logic [ADDR_W-1:0]  waddr;
    logic [BLOCK_W-1:0] wdata;
    logic [ADDR_W-1:0]  raddr;
    logic [BLOCK_W-1:0] rdata;
    logic               start;
    logic [ADDR_W-1:0]  count;
    logic               send_valid;
    logic [BYTE_W-1:0]  send_byte;
    logic               unload_busy;

    // readback owns the transmitter while it runs
    assign tx_valid = unload_busy ? send_valid : echo_valid;
    assign tx_byte  = unload_busy ? send_byte : echo_byte;

    uart_rx u_rx (
        .i_clk   (clk),
        .i_rst   (rst),
        .i_rx    (i_uart_rx),
        .o_valid (rx_valid),
        .o_byte  (rx_byte)
    );

    uart_tx u_tx (
        .clk     (clk),
        .rst     (rst),
        .i_valid (tx_valid),
        .i_byte  (tx_byte),
        .o_ready (tx_ready),
        .o_tx    (o_uart_tx)
    );

    frame_loader u_loader (
        .clk           (clk),
        .rst           (rst),
        .i_rx_valid    (rx_valid),
        .i_rx_byte     (rx_byte),
        .i_tx_ready    (tx_ready && !unload_busy),
        .i_unload_busy (unload_busy),
        .o_echo_valid  (echo_valid),
        .o_echo_byte   (echo_byte),
        .o_key         (o_key),
        .o_key_valid   (o_key_valid),
        .o_we          (we),
        .o_waddr       (waddr),
        .o_wdata       (wdata),
        .o_start       (start),
        .o_count       (count)
    );

    block_ram u_ram (
        .clk     (clk),
        .i_we    (we),
        .i_waddr (waddr),
        .i_wdata (wdata),
        .i_raddr (raddr),
        .o_rdata (rdata)
    );

    block_unloader u_unloader (
        .clk          (clk),
        .rst          (rst),
        .i_start      (start),
        .i_count      (count),
        .o_raddr      (raddr),
        .i_rdata      (rdata),
        .i_tx_ready   (tx_ready),
        .o_send_valid (send_valid),
        .o_send_byte  (send_byte),
        .o_busy       (unload_busy),
        .o_done       (o_readback_done)
    );

endmodule

/* uart_loader_checker.sv */
`timescale 1ns/1ns

module uart_loader_checker (
    input logic clk,
    input logic rst,
    input logic i_uart_tx,
    input logic i_key_valid,
    input logic i_readback_done
);

    int fail_count = 0;

    // line idles high through reset
    tx_high_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> i_uart_tx)
        else begin
            fail_count++;
            $error("o_uart_tx is low while rst is high");
        end

    key_valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
        i_key_valid |=> !i_key_valid)
        else begin
            fail_count++;
            $error("o_key_valid stayed high for more than one cycle");
        end

    done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        i_readback_done |=> !i_readback_done)
        else begin
            fail_count++;
            $error("o_readback_done stayed high for more than one cycle");
        end

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !i_key_valid && !i_readback_done)
        else begin
            fail_count++;
            $error("o_key_valid or o_readback_done high right after reset");
        end

    key_done_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(i_key_valid && i_readback_done))
        else begin
            fail_count++;
            $error("o_key_valid and o_readback_done high in the same cycle");
        end

endmodule

bind uart_loader_top uart_loader_checker u_checker (
    .clk             (clk),
    .rst             (rst),
    .i_uart_tx       (o_uart_tx),
    .i_key_valid     (o_key_valid),
    .i_readback_done (o_readback_done)
);

/* tb_uart_loader.sv */
`timescale 1ns/1ns

module tb_uart_loader import uart_loader_pkg::*; ();

    // one serial byte plus the 2 bit gap
    localparam int BYTE_CYCLES = 12 * CLKS_PER_BIT;
    // 131 bytes in and 80 readback bytes for counts 2, 0 and 3
    // doubled for margin
    localparam int TOTAL_BYTES = 3 * 17 + 5 * BYTES_PER_BLOCK + 5 * BYTES_PER_BLOCK;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_BYTES * BYTE_CYCLES;

    logic               clk;
    logic               rst;
    logic               i_uart_rx;
    logic               o_uart_tx;
    logic [BLOCK_W-1:0] o_key;
    logic               o_key_valid;
    logic               o_readback_done;

    integer             seed;
    int                 errors;
    int                 cycles;
    int                 key_pulses;
    int                 done_pulses;
    int                 key_cycle;
    int                 done_cycle;
    int                 last_start_cycle;
    logic [BLOCK_W-1:0] exp_key;
    logic [BYTE_W-1:0]  exp_q [$];
    logic [BYTE_W-1:0]  blk_bytes [0:2][0:BYTES_PER_BLOCK-1];

    uart_loader_top i_uart_loader_top (
        .clk             (clk),
        .rst             (rst),
        .i_uart_rx       (i_uart_rx),
        .o_uart_tx       (o_uart_tx),
        .o_key           (o_key),
        .o_key_valid     (o_key_valid),
        .o_readback_done (o_readback_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // 8N1 frame sent lsb first and followed by the idle gap
    task automatic send_serial(input logic [BYTE_W-1:0] b);
        logic [BYTE_W+1:0] frame;
        int                i;
        frame = {1'b1, b, 1'b0};
        for (i = 0; i < BYTE_W + 2; i++) begin
            @(posedge clk);
            i_uart_rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        repeat (2 * CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic send_and_expect(input logic [BYTE_W-1:0] b);
        exp_q.push_back(b);
        send_serial(b);
    endtask

    task automatic run_frame(input int count);
        logic [BYTE_W-1:0] b;
        int                k;
        int                i;
        key_pulses  = 0;
        done_pulses = 0;
        send_and_expect(count[BYTE_W-1:0]);
        for (i = 0; i < BYTES_PER_BLOCK; i++) begin
            b = $random(seed);
            exp_key = {exp_key[BLOCK_W-BYTE_W-1:0], b};
            send_and_expect(b);
        end
        for (k = 0; k < count; k++) begin
            for (i = 0; i < BYTES_PER_BLOCK; i++) begin
                b = $random(seed);
                blk_bytes[k][i] = b;
                send_and_expect(b);
            end
        end
        // last received byte is the block's low byte so it comes back first
        for (k = 0; k < count; k++) begin
            for (i = BYTES_PER_BLOCK - 1; i >= 0; i--) begin
                exp_q.push_back(blk_bytes[k][i]);
            end
        end
        while (done_pulses == 0 || exp_q.size() != 0) begin
            @(posedge clk);
        end
        assert (key_pulses == 1) else begin
            errors++;
            $display("** Error at %0t: o_key_valid pulses expected 1 got %0d",
                     $time, key_pulses);
        end
        assert (done_pulses == 1) else begin
            errors++;
            $display("** Error at %0t: o_readback_done pulses expected 1 got %0d",
                     $time, done_pulses);
        end
        if (count == 0) begin
            // start one cycle after the key and done one cycle after start
            assert (done_cycle == key_cycle + 2) else begin
                errors++;
                $display("** Error at %0t: o_readback_done cycle expected %0d got %0d",
                         $time, key_cycle + 2, done_cycle);
            end
        end else begin
            // done comes with the start bit of the last readback byte
            assert (done_cycle == last_start_cycle) else begin
                errors++;
                $display("** Error at %0t: o_readback_done cycle expected %0d got %0d",
                         $time, last_start_cycle, done_cycle);
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst && o_key_valid) begin
            key_pulses = key_pulses + 1;
            key_cycle  = cycles;
            assert (o_key == exp_key) else begin
                errors++;
                $display("** Error at %0t: o_key expected %h got %h", $time, exp_key, o_key);
            end
        end
        if (!rst && o_readback_done) begin
            done_pulses = done_pulses + 1;
            done_cycle  = cycles;
        end
    end

    // serial receive model on o_uart_tx with mid-bit sampling
    initial begin : tx_line_model
        logic [BYTE_W-1:0] got;
        logic [BYTE_W-1:0] want;
        int                i;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (o_uart_tx === 1'b0) begin
                last_start_cycle = cycles;
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                assert (o_uart_tx === 1'b0) else begin
                    errors++;
                    $display("start bit on o_uart_tx did not stay low at %0t", $time);
                end
                for (i = 0; i < BYTE_W; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    got[i] = o_uart_tx;
                end
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("unexpected byte %h on o_uart_tx at %0t", got, $time);
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    assert (got === want) else begin
                        errors++;
                        $display("** Error at %0t: o_uart_tx expected %h got %h",
                                 $time, want, got);
                    end
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                assert (o_uart_tx === 1'b1) else begin
                    errors++;
                    $display("stop bit on o_uart_tx was not high at %0t", $time);
                end
            end
        end
    end

    initial begin
        seed             = 32'h921e_739f;
        errors           = 0;
        cycles           = 0;
        key_pulses       = 0;
        done_pulses      = 0;
        key_cycle        = 0;
        done_cycle       = 0;
        last_start_cycle = 0;
        exp_key          = '0;
        rst              = 1'b1;
        i_uart_rx        = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (4 * CLKS_PER_BIT) @(posedge clk);
        run_frame(2);
        run_frame(0);
        run_frame(3);
        // line must stay quiet once the last readback is out
        repeat (2 * BYTE_CYCLES) @(posedge clk);
        $display("error counts: testbench %0d, assertions %0d",
                 errors, i_uart_loader_top.u_checker.fail_count);
        if (errors == 0 && i_uart_loader_top.u_checker.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
uart_loader_pkg.sv
uart_rx.sv
uart_tx.sv
frame_loader.sv
block_ram.sv
block_unloader.sv
uart_loader_top.sv
uart_loader_checker.sv
tb_uart_loader.sv
